// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module gc_tb -f list.f -Mdir obj_dir
	./obj_dir/Vgc_tb 2>&1 | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== csr_trap_unit.sv ====
/*
 * Stage 3, machine CSRs only. mstatus keeps MIE and MPIE, MPP reads as 3.
 * mtvec is direct mode. Unknown CSR addresses read zero and ignore writes.
 */
`timescale 1ns/1ps

module csr_trap_unit #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic          clk,
    input  logic          rst,
    gc_cmd_if.csr         cmd,
    output logic          fetch_pc_override,
    output logic [31:0]   fetch_pc,
    output logic          wb_valid,
    output gc_pkg::id_t   wb_id,
    output logic [31:0]   wb_data
);

    logic                 mie;
    logic                 mpie;
    logic [31:0]          mtvec;
    logic [31:0]          mscratch;
    logic [31:0]          mepc;
    gc_pkg::exc_code_t    mcause;
    logic [31:0]          mtval;
    logic [31:0]          csr_old;
    logic [31:0]          csr_new;
    logic                 csr_we;

    ////////////////////////////////////////
    // Read and modify
    always_comb begin
        case (cmd.csr_addr)
            gc_pkg::CSR_MSTATUS:  csr_old = {19'b0, 2'b11, 3'b0, mpie, 3'b0, mie, 3'b0};
            gc_pkg::CSR_MTVEC:    csr_old = mtvec;
            gc_pkg::CSR_MSCRATCH: csr_old = mscratch;
            gc_pkg::CSR_MEPC:     csr_old = mepc;
            gc_pkg::CSR_MCAUSE:   csr_old = {27'b0, mcause};
            gc_pkg::CSR_MTVAL:    csr_old = mtval;
            default:              csr_old = '0;
        endcase
    end

    always_comb begin
        case (cmd.csr_op)
            gc_pkg::CSR_RS: csr_new = csr_old | cmd.csr_operand;
            gc_pkg::CSR_RC: csr_new = csr_old & ~cmd.csr_operand;
            default:        csr_new = cmd.csr_operand;
        endcase
    end

    assign csr_we = cmd.csr_valid && cmd.csr_write;

    ////////////////////////////////////////
    // CSR state
    always_ff @(posedge clk) begin
        if (rst) begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mtvec    <= {MTVEC_RESET[31:2], 2'b00};
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= gc_pkg::exc_code_t'(5'd0);
            mtval    <= '0;
        end else if (cmd.trap_valid) begin
            // Trap entry, interrupts off
            mepc   <= cmd.trap.pc;
            mcause <= cmd.trap.code;
            mtval  <= cmd.trap.tval;
            mpie   <= mie;
            mie    <= 1'b0;
        end else if (cmd.mret) begin
            mie  <= mpie;
            mpie <= 1'b1;
        end else if (csr_we) begin
            case (cmd.csr_addr)
                gc_pkg::CSR_MSTATUS: begin
                    mie  <= csr_new[3];
                    mpie <= csr_new[7];
                end
                // Direct mode base, word aligned
                gc_pkg::CSR_MTVEC:    mtvec    <= {csr_new[31:2], 2'b00};
                gc_pkg::CSR_MSCRATCH: mscratch <= csr_new;
                gc_pkg::CSR_MEPC:     mepc     <= {csr_new[31:2], 2'b00};
                gc_pkg::CSR_MCAUSE:   mcause   <= gc_pkg::exc_code_t'(csr_new[4:0]);
                gc_pkg::CSR_MTVAL:    mtval    <= csr_new;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Write-back and redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid          <= 1'b0;
            fetch_pc_override <= 1'b0;
        end else begin
            wb_valid          <= cmd.csr_valid;
            fetch_pc_override <= cmd.trap_valid || cmd.mret || cmd.fence_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_id   <= cmd.id;
        wb_data <= csr_old;
        // mepc read before any update this cycle
        if (cmd.trap_valid) begin
            fetch_pc <= mtvec;
        end else if (cmd.mret) begin
            fetch_pc <= mepc;
        end else begin
            fetch_pc <= cmd.pc + 32'd4;
        end
    end

    // Sequencer keeps the command groups exclusive
    one_cmd_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cmd.csr_valid, cmd.trap_valid, cmd.mret, cmd.fence_i}));

endmodule

// ==== gc_cmd_if.sv ====
/*
 * Sequencer to CSR stage commands. At most one of csr_valid, trap_valid,
 * mret and fence_i is high in any cycle.
 */
`timescale 1ns/1ps

interface gc_cmd_if;
    // CSR instruction
    logic                      csr_valid;
    logic [11:0]               csr_addr;
    gc_pkg::csr_op_t           csr_op;
    logic [31:0]               csr_operand;
    logic                      csr_write;
    gc_pkg::id_t               id;
    // Trap entry
    logic                      trap_valid;
    gc_pkg::exception_packet_t trap;
    // Redirects, pc of the instruction itself
    logic                      mret;
    logic                      fence_i;
    logic [31:0]               pc;

    modport seq (
        output csr_valid, csr_addr, csr_op, csr_operand, csr_write, id,
        output trap_valid, trap, mret, fence_i, pc
    );

    modport csr (
        input csr_valid, csr_addr, csr_op, csr_operand, csr_write, id,
        input trap_valid, trap, mret, fence_i, pc
    );
endinterface

// ==== gc_decode.sv ====
/*
 * Stage 1. issue_valid must only be raised for SYSTEM or FENCE.I instructions
 * while gc_ready is high. Anything else decodes as OP_NONE and is dropped.
 */
`timescale 1ns/1ps

module gc_decode (
    input  logic          clk,
    input  logic          rst,
    input  logic          issue_valid,
    input  logic [31:0]   instruction,
    input  logic [31:0]   pc,
    input  logic [31:0]   rs1_data,
    input  gc_pkg::id_t   issue_id,
    gc_req_if.decode      req
);

    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1_field;
    logic [11:0]      imm12;
    gc_pkg::gc_op_t   op;
    gc_pkg::csr_op_t  csr_op;
    logic [31:0]      csr_operand;
    logic             csr_write;

    // Field split
    assign opcode    = instruction[6:0];
    assign funct3    = instruction[14:12];
    assign rs1_field = instruction[19:15];
    assign imm12     = instruction[31:20];

    ////////////////////////////////////////
    // Classification
    always_comb begin
        op = gc_pkg::OP_NONE;
        if (opcode == OPC_SYSTEM) begin
            if (funct3 != 3'b000) begin
                op = gc_pkg::OP_CSR;
            end else begin
                // funct12 picks the privileged op
                case (imm12)
                    12'h000: op = gc_pkg::OP_ECALL;
                    12'h001: op = gc_pkg::OP_EBREAK;
                    12'h302: op = gc_pkg::OP_MRET;
                    default: op = gc_pkg::OP_NONE;
                endcase
            end
        end else if (opcode == OPC_MISC_MEM && funct3 == 3'b001) begin
            op = gc_pkg::OP_FENCEI;
        end
    end

    // CSR operand and write flag
    assign csr_op      = gc_pkg::csr_op_t'(funct3[1:0]);
    // Immediate forms use the zero-extended rs1 field
    assign csr_operand = funct3[2] ? {27'b0, rs1_field} : rs1_data;
    // Set or clear with x0/zimm 0 is a pure read
    assign csr_write   = (csr_op == gc_pkg::CSR_RW) || (rs1_field != 5'd0);

    ////////////////////////////////////////
    // Stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= issue_valid && (op != gc_pkg::OP_NONE);
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        req.op          <= op;
        req.pc          <= pc;
        req.csr_addr    <= imm12;
        req.csr_op      <= csr_op;
        req.csr_operand <= csr_operand;
        req.csr_write   <= csr_write;
        req.id          <= issue_id;
    end

endmodule

// ==== gc_pkg.sv ====
/*
 * Machine mode only. ECALL always reports ECALL_M.
 * Instruction-queue IDs are 4 bits, which allows 16 instructions in flight.
 */

package gc_pkg;

    ////////////////////////////////////////
    // IDs and operation kinds

    // Instruction-queue ID
    typedef logic [3:0] id_t;

    // System operation kinds seen by the global control block
    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSR,
        OP_ECALL,
        OP_EBREAK,
        OP_MRET,
        OP_FENCEI
    } gc_op_t;

    // Low two bits of funct3
    // 2'b00 is not a CSR op and never reaches here
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    ////////////////////////////////////////
    // Exceptions

    // mcause codes, interrupt bit never set
    typedef enum logic [4:0] {
        BREAKPOINT       = 5'd3,
        LOAD_MISALIGNED  = 5'd4,
        LOAD_FAULT       = 5'd5,
        STORE_MISALIGNED = 5'd6,
        STORE_FAULT      = 5'd7,
        ECALL_M          = 5'd11
    } exc_code_t;

    // 5 + 32 + 32 + 4 = 73 bits
    typedef struct packed {
        exc_code_t   code;
        logic [31:0] pc;
        logic [31:0] tval;
        id_t         id;
    } exception_packet_t;

    ////////////////////////////////////////
    // Machine CSR addresses
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MTVAL    = 12'h343;

endpackage

// ==== gc_req_if.sv ====
/*
 * Decoded system request, decode to sequencer.
 * valid is a one-cycle strobe; the other fields are only meaningful with it.
 */
`timescale 1ns/1ps

interface gc_req_if;
    logic             valid;
    gc_pkg::gc_op_t   op;
    logic [31:0]      pc;
    // CSR fields, only used when op is OP_CSR
    logic [11:0]      csr_addr;
    gc_pkg::csr_op_t  csr_op;
    logic [31:0]      csr_operand;
    logic             csr_write;
    gc_pkg::id_t      id;

    modport decode (
        output valid, op, pc, csr_addr, csr_op, csr_operand, csr_write, id
    );

    modport seq (
        input valid, op, pc, csr_addr, csr_op, csr_operand, csr_write, id
    );
endinterface

// ==== gc_sequencer.sv ====
/*
 * Stage 2 control FSM. CLEAR_DEPTH must be at least 2.
 * Only one system request may be in flight; there is no back-pressure.
 */
`timescale 1ns/1ps

module gc_sequencer #(
    parameter int CLEAR_DEPTH = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    gc_req_if.seq                      req,
    gc_cmd_if.seq                      cmd,
    input  logic                       ls_issue,
    input  logic                       ls_fifo_empty,
    input  logic                       ls_exception_valid,
    input  gc_pkg::exception_packet_t  ls_exception,
    input  gc_pkg::id_t                oldest_id,
    input  logic                       iq_empty,
    output logic                       gc_ready,
    output logic                       issue_hold,
    output logic                       issue_flush,
    output logic                       supress_writeback,
    output logic                       inuse_clear,
    output logic                       fetch_flush
);

    typedef enum logic [2:0] {RST, CLEAR, IDLE, LS_POSSIBLE, DRAIN, DISCARD} state_t;

    state_t state;
    state_t next_state;

    logic [CLEAR_DEPTH-1:0]     clear_count;
    logic                       busy;
    logic                       cmd_any;
    logic                       ls_capture;
    logic                       ls_trap;
    gc_pkg::exception_packet_t  ls_held;
    gc_pkg::exception_packet_t  ls_packet;

    ////////////////////////////////////////
    // State machine
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RST:   next_state = CLEAR;
            CLEAR: if (clear_count[CLEAR_DEPTH-1]) next_state = IDLE;
            IDLE:  if (ls_issue) next_state = LS_POSSIBLE;
            LS_POSSIBLE: begin
                // Empty FIFO wins since nothing left can fault
                if (ls_fifo_empty) begin
                    next_state = IDLE;
                end else if (ls_exception_valid) begin
                    next_state = (ls_exception.id == oldest_id) ? DISCARD : DRAIN;
                end
            end
            DRAIN:   if (ls_held.id == oldest_id) next_state = DISCARD;
            DISCARD: if (iq_empty) next_state = IDLE;
            default: next_state = RST;
        endcase
    end

    // One-hot shift with bit 0 set on entry to CLEAR
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_count <= '0;
        end else begin
            clear_count <= {clear_count[CLEAR_DEPTH-2:0], state == RST};
        end
    end

    ////////////////////////////////////////
    // Load/store exception capture
    assign ls_capture = (state == LS_POSSIBLE) && !ls_fifo_empty && ls_exception_valid;
    assign ls_trap    = (next_state == DISCARD) && (state != DISCARD);
    // Straight to DISCARD uses the live packet
    assign ls_packet  = (state == LS_POSSIBLE) ? ls_exception : ls_held;

    always_ff @(posedge clk) begin
        if (ls_capture) begin
            ls_held <= ls_exception;
        end
    end

    ////////////////////////////////////////
    // Request in flight
    assign cmd_any = cmd.csr_valid || cmd.trap_valid || cmd.mret || cmd.fence_i;

    // Set on request and cleared as the command enters stage 3
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (req.valid) begin
            busy <= 1'b1;
        end else if (cmd_any) begin
            busy <= 1'b0;
        end
    end

    assign gc_ready = (state == IDLE) && !req.valid && !busy;

    ////////////////////////////////////////
    // Command strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.csr_valid  <= 1'b0;
            cmd.trap_valid <= 1'b0;
            cmd.mret       <= 1'b0;
            cmd.fence_i    <= 1'b0;
        end else begin
            cmd.csr_valid  <= req.valid && (req.op == gc_pkg::OP_CSR);
            cmd.trap_valid <= ls_trap || (req.valid &&
                              (req.op inside {gc_pkg::OP_ECALL, gc_pkg::OP_EBREAK}));
            cmd.mret       <= req.valid && (req.op == gc_pkg::OP_MRET);
            cmd.fence_i    <= req.valid && (req.op == gc_pkg::OP_FENCEI);
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        cmd.csr_addr    <= req.csr_addr;
        cmd.csr_op      <= req.csr_op;
        cmd.csr_operand <= req.csr_operand;
        cmd.csr_write   <= req.csr_write;
        cmd.id          <= req.id;
        cmd.pc          <= req.pc;
        if (ls_trap) begin
            cmd.trap <= ls_packet;
        end else begin
            // ECALL or EBREAK with a zero tval
            cmd.trap.code <= (req.op == gc_pkg::OP_ECALL) ? gc_pkg::ECALL_M
                                                          : gc_pkg::BREAKPOINT;
            cmd.trap.pc   <= req.pc;
            cmd.trap.tval <= '0;
            cmd.trap.id   <= req.id;
        end
    end

    ////////////////////////////////////////
    // Issue and fetch control
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_hold        <= 1'b0;
            issue_flush       <= 1'b0;
            supress_writeback <= 1'b0;
            inuse_clear       <= 1'b0;
            fetch_flush       <= 1'b0;
        end else begin
            issue_hold        <= req.valid ||
                                 (next_state inside {CLEAR, DRAIN, DISCARD});
            issue_flush       <= (next_state == DISCARD);
            supress_writeback <= (next_state inside {CLEAR, DISCARD});
            inuse_clear       <= (next_state == CLEAR);
            fetch_flush       <= req.valid || ls_capture;
        end
    end

    // Decode only forwards what was issued under gc_ready
    req_when_ready: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> (state == IDLE) && !busy);

    // Clear pulse lines up with a single counter bit
    clear_only_in_clear: assert property (@(posedge clk) disable iff (rst)
        inuse_clear |-> (state == CLEAR) && $onehot(clear_count));

endmodule

// ==== gc_tb.sv ====
/*
 * Directed testbench for gc_top with default parameters.
 * Models fetch, issue, the instruction queue and the load/store unit.
 */
`timescale 1ns/1ps

module gc_tb;

    localparam int          CLEAR_DEPTH = 32;
    localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;
    localparam int          TIMEOUT     = 200;
    // Issue negedge counts as 1, results show at the third negedge
    localparam int          LATENCY     = 3;

    logic clk;
    logic rst;
    logic issue_valid;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    gc_pkg::id_t issue_id;
    logic gc_ready;
    logic ls_issue;
    logic ls_fifo_empty;
    logic ls_exception_valid;
    gc_pkg::exception_packet_t ls_exception;
    gc_pkg::id_t oldest_id;
    logic iq_empty;
    logic issue_hold;
    logic issue_flush;
    logic supress_writeback;
    logic inuse_clear;
    logic fetch_flush;
    logic fetch_pc_override;
    logic [31:0] fetch_pc;
    logic wb_valid;
    gc_pkg::id_t wb_id;
    logic [31:0] wb_data;

    integer seed;
    logic [31:0] next_pc;
    gc_pkg::id_t next_id;
    logic [31:0] last_pc;
    gc_pkg::id_t last_id;

    // Expected CSR contents
    logic [31:0] exp_mtvec;
    logic [31:0] exp_mscratch;
    logic [31:0] exp_mepc;
    logic [31:0] exp_mcause;
    logic [31:0] exp_mtval;

    gc_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Checks

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input gc_pkg::id_t got, input gc_pkg::id_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // CSR model and encoding

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            gc_pkg::CSR_MTVEC:    return exp_mtvec;
            gc_pkg::CSR_MSCRATCH: return exp_mscratch;
            gc_pkg::CSR_MEPC:     return exp_mepc;
            gc_pkg::CSR_MCAUSE:   return exp_mcause;
            gc_pkg::CSR_MTVAL:    return exp_mtval;
            default:              return 32'h0;
        endcase
    endfunction

    // Only the CSRs written by the tests
    function automatic void model_write(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            gc_pkg::CSR_MTVEC:    exp_mtvec = {val[31:2], 2'b00};
            gc_pkg::CSR_MSCRATCH: exp_mscratch = val;
            gc_pkg::CSR_MTVAL:    exp_mtval = val;
            default: ;
        endcase
    endfunction

    // rd fixed at x1
    function automatic logic [31:0] enc_csr(input logic [2:0] funct3, input logic [11:0] addr,
                                            input logic [4:0] rs1);
        return {addr, rs1, funct3, 5'd1, 7'b1110011};
    endfunction

    ////////////////////////////////////////
    // Issue side

    task automatic wait_ready();
        int t;
        t = 0;
        while (!gc_ready) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) stop_on_error("timeout waiting for gc_ready");
        end
    endtask

    task automatic issue_one(input logic [31:0] instr, input logic [31:0] rs1_val);
        wait_ready();
        issue_valid = 1'b1;
        instruction = instr;
        pc = next_pc;
        rs1_data = rs1_val;
        issue_id = next_id;
        last_pc = next_pc;
        last_id = next_id;
        next_pc = next_pc + 32'd4;
        next_id = next_id + 4'd1;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    // One CSR instruction, old value back, model updated
    task automatic do_csr(input logic [2:0] funct3, input logic [11:0] addr,
                          input logic [4:0] rs1_field, input logic [31:0] rs1_val);
        logic [31:0] old_val;
        logic [31:0] operand;
        logic [31:0] new_val;
        logic writes;
        int lat;
        old_val = model_read(addr);
        operand = funct3[2] ? {27'b0, rs1_field} : rs1_val;
        // Set or clear with zero rs1 field is a read only
        writes = (funct3[1:0] == 2'b01) || (rs1_field != 5'd0);
        case (funct3[1:0])
            2'b10:   new_val = old_val | operand;
            2'b11:   new_val = old_val & ~operand;
            default: new_val = operand;
        endcase
        issue_one(enc_csr(funct3, addr, rs1_field), rs1_val);
        lat = 1;
        while (!wb_valid) begin
            check_bit("fetch_pc_override", fetch_pc_override, 1'b0);
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT) stop_on_error("timeout waiting for wb_valid");
        end
        if (lat != LATENCY) begin
            stop_on_error($sformatf("wb_valid came %0d cycles after issue", lat));
        end
        check_id("wb_id", wb_id, last_id);
        check_word("wb_data", wb_data, old_val);
        if (writes) model_write(addr, new_val);
    endtask

    // ECALL, EBREAK, MRET or FENCE.I and its redirect
    task automatic do_system(input gc_pkg::gc_op_t op);
        logic [31:0] instr;
        logic [31:0] exp_pc;
        logic saw_flush;
        int lat;
        case (op)
            gc_pkg::OP_ECALL:  instr = 32'h0000_0073;
            gc_pkg::OP_EBREAK: instr = 32'h0010_0073;
            gc_pkg::OP_MRET:   instr = 32'h3020_0073;
            default:           instr = 32'h0000_100f;
        endcase
        if (op == gc_pkg::OP_MRET) exp_pc = exp_mepc;
        else if (op == gc_pkg::OP_FENCEI) exp_pc = next_pc + 32'd4;
        else exp_pc = exp_mtvec;
        issue_one(instr, 32'h0);
        lat = 1;
        saw_flush = fetch_flush;
        while (!fetch_pc_override) begin
            check_bit("wb_valid", wb_valid, 1'b0);
            @(negedge clk);
            lat++;
            saw_flush = saw_flush | fetch_flush;
            if (lat > TIMEOUT) stop_on_error("timeout waiting for fetch_pc_override");
        end
        if (lat != LATENCY) begin
            stop_on_error($sformatf("redirect came %0d cycles after issue", lat));
        end
        if (!saw_flush) stop_on_error("no fetch_flush pulse before the redirect");
        check_word("fetch_pc", fetch_pc, exp_pc);
        if (op == gc_pkg::OP_ECALL || op == gc_pkg::OP_EBREAK) begin
            exp_mepc = last_pc;
            exp_mcause = (op == gc_pkg::OP_ECALL) ? 32'd11 : 32'd3;
            exp_mtval = 32'h0;
        end
    endtask

    ////////////////////////////////////////
    // Tests

    task automatic reset_clear_test();
        int t;
        int clear_cycles;
        // Still in reset, no pulses
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("fetch_pc_override", fetch_pc_override, 1'b0);
        check_bit("fetch_flush", fetch_flush, 1'b0);
        check_bit("inuse_clear", inuse_clear, 1'b0);
        rst = 1'b0;
        t = 0;
        clear_cycles = 0;
        while (!gc_ready) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) stop_on_error("timeout waiting for the end of the clear");
            if (inuse_clear) begin
                clear_cycles++;
                check_bit("issue_hold", issue_hold, 1'b1);
                check_bit("supress_writeback", supress_writeback, 1'b1);
                check_bit("gc_ready", gc_ready, 1'b0);
            end
        end
        check_bit("inuse_clear", inuse_clear, 1'b0);
        if (clear_cycles != CLEAR_DEPTH) begin
            stop_on_error($sformatf("inuse_clear was high for %0d cycles", clear_cycles));
        end
    endtask

    task automatic csr_ops_test();
        do_csr(3'b001, gc_pkg::CSR_MSCRATCH, 5'd7, $random(seed));
        do_csr(3'b010, gc_pkg::CSR_MSCRATCH, 5'd8, $random(seed));
        do_csr(3'b011, gc_pkg::CSR_MSCRATCH, 5'd9, $random(seed));
        // Immediate forms, rs1_data must be ignored
        do_csr(3'b110, gc_pkg::CSR_MSCRATCH, 5'h1a, $random(seed));
        do_csr(3'b111, gc_pkg::CSR_MSCRATCH, 5'h03, $random(seed));
        do_csr(3'b101, gc_pkg::CSR_MTVEC, 5'h1f, 32'h0);
        do_csr(3'b001, gc_pkg::CSR_MTVEC, 5'd4, $random(seed));
        // Zero rs1 field, no write even with data present
        do_csr(3'b010, gc_pkg::CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        do_csr(3'b011, gc_pkg::CSR_MTVEC, 5'd0, 32'hffff_ffff);
        do_csr(3'b111, gc_pkg::CSR_MSCRATCH, 5'd0, 32'h0);
        do_csr(3'b010, gc_pkg::CSR_MSCRATCH, 5'd0, 32'h0);
        do_csr(3'b010, gc_pkg::CSR_MTVEC, 5'd0, 32'h0);
    endtask

    task automatic trap_test();
        // Nonzero mtval first so the trap clear is visible
        do_csr(3'b001, gc_pkg::CSR_MTVAL, 5'd3, $random(seed));
        do_system(gc_pkg::OP_ECALL);
        do_csr(3'b010, gc_pkg::CSR_MEPC, 5'd0, 32'h0);
        do_csr(3'b010, gc_pkg::CSR_MCAUSE, 5'd0, 32'h0);
        do_csr(3'b010, gc_pkg::CSR_MTVAL, 5'd0, 32'h0);
        do_system(gc_pkg::OP_EBREAK);
        do_csr(3'b010, gc_pkg::CSR_MCAUSE, 5'd0, 32'h0);
        do_csr(3'b010, gc_pkg::CSR_MEPC, 5'd0, 32'h0);
    endtask

    task automatic ls_drain_test();
        gc_pkg::exception_packet_t pkt;
        int t;
        pkt.code = gc_pkg::LOAD_FAULT;
        pkt.pc = 32'h0000_3a10;
        pkt.tval = $random(seed);
        pkt.id = 4'd9;
        wait_ready();
        ls_issue = 1'b1;
        ls_fifo_empty = 1'b0;
        iq_empty = 1'b0;
        oldest_id = 4'd6;
        @(negedge clk);
        ls_issue = 1'b0;
        ls_exception_valid = 1'b1;
        ls_exception = pkt;
        @(negedge clk);
        ls_exception_valid = 1'b0;
        check_bit("fetch_flush", fetch_flush, 1'b1);
        // Older instructions still draining
        repeat (6) begin
            check_bit("issue_hold", issue_hold, 1'b1);
            check_bit("issue_flush", issue_flush, 1'b0);
            check_bit("fetch_pc_override", fetch_pc_override, 1'b0);
            @(negedge clk);
        end
        oldest_id = pkt.id;
        t = 0;
        while (!fetch_pc_override) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) stop_on_error("timeout waiting for the load/store redirect");
        end
        check_word("fetch_pc", fetch_pc, exp_mtvec);
        repeat (4) begin
            check_bit("issue_flush", issue_flush, 1'b1);
            check_bit("supress_writeback", supress_writeback, 1'b1);
            @(negedge clk);
        end
        iq_empty = 1'b1;
        wait_ready();
        check_bit("issue_flush", issue_flush, 1'b0);
        ls_fifo_empty = 1'b1;
        oldest_id = 4'd0;
        exp_mepc = pkt.pc;
        exp_mcause = 32'd5;
        exp_mtval = pkt.tval;
        do_csr(3'b010, gc_pkg::CSR_MCAUSE, 5'd0, 32'h0);
        do_csr(3'b010, gc_pkg::CSR_MEPC, 5'd0, 32'h0);
        do_csr(3'b010, gc_pkg::CSR_MTVAL, 5'd0, 32'h0);
    endtask

    task automatic ls_window_test();
        wait_ready();
        ls_issue = 1'b1;
        ls_fifo_empty = 1'b0;
        @(negedge clk);
        ls_issue = 1'b0;
        repeat (4) begin
            check_bit("gc_ready", gc_ready, 1'b0);
            check_bit("fetch_pc_override", fetch_pc_override, 1'b0);
            @(negedge clk);
        end
        // Nothing left that can fault
        ls_fifo_empty = 1'b1;
        wait_ready();
        check_bit("fetch_pc_override", fetch_pc_override, 1'b0);
        do_csr(3'b001, gc_pkg::CSR_MSCRATCH, 5'd2, $random(seed));
    endtask

    initial begin
        seed = 32'h2979_337f;
        rst = 1'b1;
        issue_valid = 1'b0;
        instruction = '0;
        pc = '0;
        rs1_data = '0;
        issue_id = '0;
        ls_issue = 1'b0;
        ls_fifo_empty = 1'b1;
        ls_exception_valid = 1'b0;
        ls_exception = '0;
        oldest_id = '0;
        iq_empty = 1'b1;
        next_pc = 32'h0000_1000;
        next_id = '0;
        last_pc = '0;
        last_id = '0;
        exp_mtvec = {MTVEC_RESET[31:2], 2'b00};
        exp_mscratch = '0;
        exp_mepc = '0;
        exp_mcause = '0;
        exp_mtval = '0;
        repeat (16) @(negedge clk);
        reset_clear_test();
        csr_ops_test();
        trap_test();
        do_system(gc_pkg::OP_MRET);
        do_system(gc_pkg::OP_FENCEI);
        ls_drain_test();
        ls_window_test();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== gc_top.sv ====
/*
 * Global control block. issue_valid only while gc_ready is high,
 * one system instruction in flight. Load/store exceptions arrive as pulses.
 */
`timescale 1ns/1ps

module gc_top #(
    parameter int          CLEAR_DEPTH = 32,
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                       clk,
    input  logic                       rst,
    // Issue
    input  logic                       issue_valid,
    input  logic [31:0]                instruction,
    input  logic [31:0]                pc,
    input  logic [31:0]                rs1_data,
    input  gc_pkg::id_t                issue_id,
    output logic                       gc_ready,
    // Load/store unit
    input  logic                       ls_issue,
    input  logic                       ls_fifo_empty,
    input  logic                       ls_exception_valid,
    input  gc_pkg::exception_packet_t  ls_exception,
    // Instruction queue
    input  gc_pkg::id_t                oldest_id,
    input  logic                       iq_empty,
    // Issue and fetch control
    output logic                       issue_hold,
    output logic                       issue_flush,
    output logic                       supress_writeback,
    output logic                       inuse_clear,
    output logic                       fetch_flush,
    output logic                       fetch_pc_override,
    output logic [31:0]                fetch_pc,
    // CSR write-back
    output logic                       wb_valid,
    output gc_pkg::id_t                wb_id,
    output logic [31:0]                wb_data
);

    gc_req_if req ();
    gc_cmd_if cmd ();

    gc_decode u_decode (.*);

    gc_sequencer #(.CLEAR_DEPTH(CLEAR_DEPTH)) u_sequencer (.*);

    csr_trap_unit #(.MTVEC_RESET(MTVEC_RESET)) u_csr (.*);

endmodule

// ==== list.f ====
gc_pkg.sv
gc_req_if.sv
gc_cmd_if.sv
gc_decode.sv
gc_sequencer.sv
csr_trap_unit.sv
gc_top.sv
gc_tb.sv
